/* source/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    // buffer geometry
    localparam int ROB_DEPTH = 16;
    localparam int TAG_W     = $clog2(ROB_DEPTH);

    // operand and result widths
    localparam int REG_W     = 5;
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;

    // one extra bit so a completely full buffer can be counted
    localparam int CNT_W     = TAG_W + 1;

    // what an entry does when it reaches the head
    typedef enum logic [1:0] {
        KIND_ALU    = 2'd0,
        KIND_STORE  = 2'd1,
        KIND_BRANCH = 2'd2
    } rob_kind_t;

    // commit fsm encoding
    localparam int STATE_W = 2;

    localparam logic [STATE_W-1:0] ST_RUN        = 2'd0;
    localparam logic [STATE_W-1:0] ST_STORE_WAIT = 2'd1;
    localparam logic [STATE_W-1:0] ST_FLUSH      = 2'd2;

endpackage

`default_nettype wire

/* source/rob_ptr_counter.sv */
`default_nettype none

module rob_ptr_counter (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      alloc_en,
    input  logic                      pop,
    input  logic                      flush,
    output logic                      push,
    output logic [rob_pkg::TAG_W-1:0] head,
    output logic [rob_pkg::TAG_W-1:0] tail,
    output logic                      full
);

    logic [rob_pkg::TAG_W-1:0] head_q;
    logic [rob_pkg::TAG_W-1:0] tail_q;
    logic [rob_pkg::CNT_W-1:0] count_q;

    // while flush is high the buffer already looks empty
    assign head = head_q;
    assign tail = flush ? '0 : tail_q;
    assign full = !flush && (count_q == rob_pkg::CNT_W'(rob_pkg::ROB_DEPTH));

    assign push = alloc_en && !full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush) begin
            // restart at tag 0, keeping an allocation made during the flush
            head_q  <= '0;
            tail_q  <= rob_pkg::TAG_W'(push);
            count_q <= rob_pkg::CNT_W'(push);
        end else begin
            if (push) begin
                tail_q <= tail_q + rob_pkg::TAG_W'(1);
            end

            if (pop) begin
                head_q <= head_q + rob_pkg::TAG_W'(1);
            end

            case ({push, pop})
                2'b10: begin
                    count_q <= count_q + rob_pkg::CNT_W'(1);
                end
                2'b01: begin
                    count_q <= count_q - rob_pkg::CNT_W'(1);
                end
                default: begin
                    // both or neither leave the count alone
                    count_q <= count_q;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/rob_entry_store.sv */
`default_nettype none

module rob_entry_store (
    input  logic                       clk,
    input  logic                       arst_n,

    // allocation at the tail
    input  logic                       push,
    input  logic [rob_pkg::TAG_W-1:0]  tail,
    input  rob_pkg::rob_kind_t         alloc_kind,
    input  logic [rob_pkg::REG_W-1:0]  alloc_rd,
    input  logic                       alloc_pred,

    // execute writeback
    input  logic                       ex_en,
    input  logic [rob_pkg::TAG_W-1:0]  ex_tag,
    input  logic [rob_pkg::DATA_W-1:0] ex_data,
    input  logic                       ex_taken,
    input  logic [rob_pkg::ADDR_W-1:0] ex_target,

    // retirement side
    input  logic [rob_pkg::TAG_W-1:0]  head,
    input  logic                       pop,
    input  logic                       flush,

    output logic                       head_valid,
    output logic                       head_done,
    output rob_pkg::rob_kind_t         head_kind,
    output logic [rob_pkg::REG_W-1:0]  head_rd,
    output logic [rob_pkg::DATA_W-1:0] head_data,
    output logic                       head_pred,
    output logic                       head_taken,
    output logic [rob_pkg::ADDR_W-1:0] head_target
);

    // per-entry status
    logic [rob_pkg::ROB_DEPTH-1:0] valid_q;
    logic [rob_pkg::ROB_DEPTH-1:0] done_q;

    // per-entry payload
    rob_pkg::rob_kind_t         kind_q   [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::REG_W-1:0]  rd_q     [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::DATA_W-1:0] data_q   [rob_pkg::ROB_DEPTH];
    logic                       pred_q   [rob_pkg::ROB_DEPTH];
    logic                       taken_q  [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::ADDR_W-1:0] target_q [rob_pkg::ROB_DEPTH];

    logic wb_hit;

    // results for empty slots are dropped
    assign wb_hit = ex_en && valid_q[ex_tag] && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            if (wb_hit) begin
                done_q[ex_tag] <= 1'b1;
            end

            if (pop) begin
                valid_q[head] <= 1'b0;
                done_q[head]  <= 1'b0;
            end

            if (flush) begin
                valid_q <= '0;
                done_q  <= '0;
            end

            // tail is already 0 during a flush
            if (push) begin
                valid_q[tail] <= 1'b1;
                done_q[tail]  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            kind_q[tail] <= alloc_kind;
            rd_q[tail]   <= alloc_rd;
            pred_q[tail] <= alloc_pred;
        end

        if (wb_hit) begin
            data_q[ex_tag]   <= ex_data;
            taken_q[ex_tag]  <= ex_taken;
            target_q[ex_tag] <= ex_target;
        end
    end

    // head view for the commit fsm
    assign head_valid  = valid_q[head];
    assign head_done   = done_q[head];
    assign head_kind   = kind_q[head];
    assign head_rd     = rd_q[head];
    assign head_data   = data_q[head];
    assign head_pred   = pred_q[head];
    assign head_taken  = taken_q[head];
    assign head_target = target_q[head];

endmodule

`default_nettype wire

/* source/rob_commit_fsm.sv */
`default_nettype none

module rob_commit_fsm (
    input  logic                       clk,
    input  logic                       arst_n,

    // head entry
    input  logic                       head_valid,
    input  logic                       head_done,
    input  rob_pkg::rob_kind_t         head_kind,
    input  logic [rob_pkg::REG_W-1:0]  head_rd,
    input  logic [rob_pkg::DATA_W-1:0] head_data,
    input  logic                       head_pred,
    input  logic                       head_taken,
    input  logic [rob_pkg::ADDR_W-1:0] head_target,
    input  logic [rob_pkg::TAG_W-1:0]  head,

    input  logic                       store_done,

    output logic                       pop,

    // register file writeback
    output logic                       rf_en,
    output logic [rob_pkg::REG_W-1:0]  rf_rd,
    output logic [rob_pkg::DATA_W-1:0] rf_data,
    output logic [rob_pkg::TAG_W-1:0]  rf_tag,

    // store buffer issue
    output logic                       store_en,
    output logic [rob_pkg::TAG_W-1:0]  store_tag,

    output logic                       flush,
    output logic [rob_pkg::ADDR_W-1:0] redirect_pc
);

    logic [rob_pkg::STATE_W-1:0] state_q;
    logic [rob_pkg::STATE_W-1:0] state_d;

    logic do_write;
    logic do_store;
    logic do_flush;
    logic mispredict;

    assign mispredict = (head_kind == rob_pkg::KIND_BRANCH) && (head_pred != head_taken);

    always_comb begin
        state_d  = state_q;
        pop      = 1'b0;
        do_write = 1'b0;
        do_store = 1'b0;
        do_flush = 1'b0;

        case (state_q)
            rob_pkg::ST_RUN: begin
                if (head_valid && head_kind == rob_pkg::KIND_STORE) begin
                    // stores need no result, only the buffer's ack
                    do_store = 1'b1;
                    state_d  = rob_pkg::ST_STORE_WAIT;
                end else if (head_valid && head_done) begin
                    do_write = 1'b1;
                    if (mispredict) begin
                        // branch stays put, the flush wipes it
                        do_flush = 1'b1;
                        state_d  = rob_pkg::ST_FLUSH;
                    end else begin
                        pop = 1'b1;
                    end
                end
            end
            rob_pkg::ST_STORE_WAIT: begin
                if (store_done) begin
                    pop     = 1'b1;
                    state_d = rob_pkg::ST_RUN;
                end
            end
            rob_pkg::ST_FLUSH: begin
                state_d = rob_pkg::ST_RUN;
            end
            default: begin
                state_d = rob_pkg::ST_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= rob_pkg::ST_RUN;
            rf_en    <= 1'b0;
            store_en <= 1'b0;
            flush    <= 1'b0;
        end else begin
            state_q  <= state_d;
            rf_en    <= do_write;
            store_en <= do_store;
            flush    <= do_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            rf_rd   <= head_rd;
            rf_data <= head_data;
            rf_tag  <= head;
        end

        if (do_store) begin
            store_tag <= head;
        end

        if (do_flush) begin
            redirect_pc <= head_target;
        end
    end

endmodule

`default_nettype wire

/* source/rob_top.sv */
`default_nettype none

module rob_top (
    input  logic                       clk,
    input  logic                       arst_n,

    // dispatch
    input  logic                       alloc_en,
    input  rob_pkg::rob_kind_t         alloc_kind,
    input  logic [rob_pkg::REG_W-1:0]  alloc_rd,
    input  logic                       alloc_pred,
    output logic [rob_pkg::TAG_W-1:0]  alloc_tag,
    output logic                       full,

    // execute
    input  logic                       ex_en,
    input  logic [rob_pkg::TAG_W-1:0]  ex_tag,
    input  logic [rob_pkg::DATA_W-1:0] ex_data,
    input  logic                       ex_taken,
    input  logic [rob_pkg::ADDR_W-1:0] ex_target,

    // store buffer
    input  logic                       store_done,
    output logic                       store_en,
    output logic [rob_pkg::TAG_W-1:0]  store_tag,

    // register file
    output logic                       rf_en,
    output logic [rob_pkg::REG_W-1:0]  rf_rd,
    output logic [rob_pkg::DATA_W-1:0] rf_data,
    output logic [rob_pkg::TAG_W-1:0]  rf_tag,

    output logic                       flush,
    output logic [rob_pkg::ADDR_W-1:0] redirect_pc
);

    logic                       push;
    logic                       pop;
    logic [rob_pkg::TAG_W-1:0]  head;
    logic [rob_pkg::TAG_W-1:0]  tail;

    logic                       head_valid;
    logic                       head_done;
    rob_pkg::rob_kind_t         head_kind;
    logic [rob_pkg::REG_W-1:0]  head_rd;
    logic [rob_pkg::DATA_W-1:0] head_data;
    logic                       head_pred;
    logic                       head_taken;
    logic [rob_pkg::ADDR_W-1:0] head_target;

    // new tag is visible in the allocation cycle
    assign alloc_tag = tail;

    rob_ptr_counter rob_ptr_counter_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .alloc_en (alloc_en),
        .pop      (pop),
        .flush    (flush),
        .push     (push),
        .head     (head),
        .tail     (tail),
        .full     (full)
    );

    rob_entry_store rob_entry_store_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .push        (push),
        .tail        (tail),
        .alloc_kind  (alloc_kind),
        .alloc_rd    (alloc_rd),
        .alloc_pred  (alloc_pred),
        .ex_en       (ex_en),
        .ex_tag      (ex_tag),
        .ex_data     (ex_data),
        .ex_taken    (ex_taken),
        .ex_target   (ex_target),
        .head        (head),
        .pop         (pop),
        .flush       (flush),
        .head_valid  (head_valid),
        .head_done   (head_done),
        .head_kind   (head_kind),
        .head_rd     (head_rd),
        .head_data   (head_data),
        .head_pred   (head_pred),
        .head_taken  (head_taken),
        .head_target (head_target)
    );

    rob_commit_fsm rob_commit_fsm_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .head_valid  (head_valid),
        .head_done   (head_done),
        .head_kind   (head_kind),
        .head_rd     (head_rd),
        .head_data   (head_data),
        .head_pred   (head_pred),
        .head_taken  (head_taken),
        .head_target (head_target),
        .head        (head),
        .store_done  (store_done),
        .pop         (pop),
        .rf_en       (rf_en),
        .rf_rd       (rf_rd),
        .rf_data     (rf_data),
        .rf_tag      (rf_tag),
        .store_en    (store_en),
        .store_tag   (store_tag),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

endmodule

`default_nettype wire

/* bench/rob_assertions.sv */
`default_nettype none

module rob_assertions (
    input logic                                clk,
    input logic                                arst_n,
    input logic                                push,
    input logic [rob_pkg::TAG_W-1:0]           tail,
    input logic                                flush,
    input logic                                rf_en,
    input logic                                store_en,
    input logic                                ex_en,
    input logic [rob_pkg::TAG_W-1:0]           ex_tag,
    input logic [rob_pkg::ROB_DEPTH-1:0]       entry_valid
);

    timeunit 1ns;
    timeprecision 1ns;

    flush_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !flush)
        else $error("flush held for more than one cycle");

    // a push while full would land on the live head entry
    push_into_free_slot: assert property (@(posedge clk) disable iff (!arst_n)
        push && !flush |-> !entry_valid[tail])
        else $error("push onto an entry that is still live");

    wb_to_valid_entry: assert property (@(posedge clk) disable iff (!arst_n)
        ex_en |-> entry_valid[ex_tag])
        else $error("writeback to an entry that is not valid");

    // a store never writes the register file
    store_not_with_rf: assert property (@(posedge clk) disable iff (!arst_n)
        !(store_en && rf_en))
        else $error("store_en and rf_en high together");

endmodule

bind rob_top rob_assertions rob_assertions_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .push        (push),
    .tail        (tail),
    .flush       (flush),
    .rf_en       (rf_en),
    .store_en    (store_en),
    .ex_en       (ex_en),
    .ex_tag      (ex_tag),
    .entry_valid (rob_entry_store_i.valid_q)
);

`default_nettype wire

/* bench/rob_tb.sv */
`default_nettype none

module rob_tb;

    timeunit 1ns;
    timeprecision 1ns;

    typedef enum logic [2:0] {
        OP_IDLE, OP_ALLOC, OP_EXEC, OP_EXEC_ALL, OP_SDONE, OP_DRAIN
    } op_t;

    typedef struct {
        op_t                        op;
        rob_pkg::rob_kind_t         kind;
        logic [rob_pkg::REG_W-1:0]  rd;
        logic [rob_pkg::TAG_W-1:0]  tag;
        logic                       pred;
        logic                       taken;
        logic [rob_pkg::ADDR_W-1:0] target;
        int                         cnt;
    } row_t;

    localparam int N_ROWS = 28;

    // op, kind, rd, tag, pred, taken, target, repeat
    row_t rows [N_ROWS] = '{
        '{OP_ALLOC, rob_pkg::KIND_ALU, 5'd1, 4'd0, 1'b0, 1'b0, 32'h0, 6},
        '{OP_EXEC_ALL, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_DRAIN, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_ALLOC, rob_pkg::KIND_ALU, 5'd8, 4'd0, 1'b0, 1'b0, 32'h0, 4},
        '{OP_ALLOC, rob_pkg::KIND_STORE, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_ALLOC, rob_pkg::KIND_ALU, 5'd12, 4'd0, 1'b0, 1'b0, 32'h0, 3},
        '{OP_EXEC_ALL, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_IDLE, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 6},
        '{OP_SDONE, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_DRAIN, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_ALLOC, rob_pkg::KIND_ALU, 5'd16, 4'd0, 1'b0, 1'b0, 32'h0, 18},
        '{OP_EXEC, rob_pkg::KIND_ALU, 5'd0, 4'd14, 1'b0, 1'b0, 32'h0, 1},
        '{OP_IDLE, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 3},
        '{OP_EXEC_ALL, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_DRAIN, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_ALLOC, rob_pkg::KIND_BRANCH, 5'd3, 4'd0, 1'b1, 1'b0, 32'h0, 1},
        '{OP_EXEC, rob_pkg::KIND_ALU, 5'd0, 4'd14, 1'b0, 1'b1, 32'h0000_2040, 1},
        '{OP_DRAIN, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_ALLOC, rob_pkg::KIND_ALU, 5'd5, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_ALLOC, rob_pkg::KIND_BRANCH, 5'd6, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_ALLOC, rob_pkg::KIND_ALU, 5'd7, 4'd0, 1'b0, 1'b0, 32'h0, 3},
        '{OP_EXEC_ALL, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_EXEC, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b1, 32'h8000_0100, 1},
        '{OP_DRAIN, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_IDLE, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 4},
        '{OP_ALLOC, rob_pkg::KIND_ALU, 5'd20, 4'd0, 1'b0, 1'b0, 32'h0, 2},
        '{OP_EXEC_ALL, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1},
        '{OP_DRAIN, rob_pkg::KIND_ALU, 5'd0, 4'd0, 1'b0, 1'b0, 32'h0, 1}
    };

    logic                       clk;
    logic                       arst_n;
    logic                       alloc_en;
    rob_pkg::rob_kind_t         alloc_kind;
    logic [rob_pkg::REG_W-1:0]  alloc_rd;
    logic                       alloc_pred;
    logic [rob_pkg::TAG_W-1:0]  alloc_tag;
    logic                       full;
    logic                       ex_en;
    logic [rob_pkg::TAG_W-1:0]  ex_tag;
    logic [rob_pkg::DATA_W-1:0] ex_data;
    logic                       ex_taken;
    logic [rob_pkg::ADDR_W-1:0] ex_target;
    logic                       store_done;
    logic                       store_en;
    logic [rob_pkg::TAG_W-1:0]  store_tag;
    logic                       rf_en;
    logic [rob_pkg::REG_W-1:0]  rf_rd;
    logic [rob_pkg::DATA_W-1:0] rf_data;
    logic [rob_pkg::TAG_W-1:0]  rf_tag;
    logic                       flush;
    logic [rob_pkg::ADDR_W-1:0] redirect_pc;

    // reference model, indexed by tag
    logic                       m_valid  [rob_pkg::ROB_DEPTH];
    logic                       m_done   [rob_pkg::ROB_DEPTH];
    rob_pkg::rob_kind_t         m_kind   [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::REG_W-1:0]  m_rd     [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::DATA_W-1:0] m_data   [rob_pkg::ROB_DEPTH];
    logic                       m_pred   [rob_pkg::ROB_DEPTH];
    logic                       m_taken  [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::ADDR_W-1:0] m_target [rob_pkg::ROB_DEPTH];
    int                         order [$];
    logic [rob_pkg::TAG_W-1:0]  tail_m;
    logic                       store_seen;
    logic                       store_pop;
    logic [31:0]                rng;

    rob_top rob_top_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort(input string what);
        $display("error at %0t: %s", $time, what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
            m_done[i]  = 1'b0;
        end
        order.delete();
        tail_m     = '0;
        store_seen = 1'b0;
    endtask

    // compare what the last edge produced with the model
    task automatic observe();
        int  t;
        logic mis;
        if (store_pop) begin
            m_valid[order[0]] = 1'b0;
            void'(order.pop_front());
            store_pop = 1'b0;
        end
        if (rf_en) begin
            if (order.size() == 0) begin
                abort("rf_en rose with no entry in flight");
            end
            t = order[0];
            check("rf_tag", 32'(rf_tag), 32'(t));
            check("rf_rd", 32'(rf_rd), 32'(m_rd[t]));
            check("rf_data", rf_data, m_data[t]);
            check("head done", 32'(m_done[t]), 32'd1);
            mis = (m_kind[t] == rob_pkg::KIND_BRANCH) && (m_pred[t] != m_taken[t]);
            check("flush", 32'(flush), 32'(mis));
            if (mis) begin
                check("redirect_pc", redirect_pc, m_target[t]);
                clear_model();
            end else begin
                m_valid[t] = 1'b0;
                void'(order.pop_front());
            end
        end else begin
            check("flush", 32'(flush), 32'd0);
        end
        if (store_en) begin
            if (order.size() == 0) begin
                abort("store_en rose with no entry in flight");
            end
            check("store_tag", 32'(store_tag), 32'(order[0]));
            check("store kind", 32'(m_kind[order[0]]), 32'(rob_pkg::KIND_STORE));
            store_seen = 1'b1;
        end
        check("alloc_tag", 32'(alloc_tag), 32'(tail_m));
        check("full", 32'(full), 32'(order.size() == rob_pkg::ROB_DEPTH));
    endtask

    task automatic tick();
        @(negedge clk);
        observe();
        alloc_en   = 1'b0;
        ex_en      = 1'b0;
        store_done = 1'b0;
    endtask

    task automatic drive_exec(input int t, input logic taken, input logic [31:0] target);
        rng       = xorshift(rng);
        ex_en     = 1'b1;
        ex_tag    = t[rob_pkg::TAG_W-1:0];
        ex_data   = rng;
        ex_taken  = taken;
        ex_target = target;
        if (m_valid[t]) begin
            m_done[t]   = 1'b1;
            m_data[t]   = rng;
            m_taken[t]  = taken;
            m_target[t] = target;
        end
    endtask

    task automatic run_row(input row_t r);
        int list [$];
        int j;
        int tmp;
        int n;
        case (r.op)
            OP_ALLOC: begin
                for (int i = 0; i < r.cnt; i++) begin
                    tick();
                    alloc_en   = 1'b1;
                    alloc_kind = r.kind;
                    alloc_rd   = r.rd + 5'(i);
                    alloc_pred = r.pred;
                    if (order.size() < rob_pkg::ROB_DEPTH) begin
                        m_valid[tail_m] = 1'b1;
                        m_done[tail_m]  = 1'b0;
                        m_kind[tail_m]  = r.kind;
                        m_rd[tail_m]    = r.rd + 5'(i);
                        m_pred[tail_m]  = r.pred;
                        order.push_back(int'(tail_m));
                        tail_m = tail_m + 1'b1;
                    end
                end
            end
            OP_EXEC: begin
                tick();
                drive_exec(int'(r.tag), r.taken, r.target);
            end
            OP_EXEC_ALL: begin
                foreach (order[k]) begin
                    if (!m_done[order[k]] && m_kind[order[k]] == rob_pkg::KIND_ALU) begin
                        list.push_back(order[k]);
                    end
                end
                // shuffle so results come back out of order
                for (int i = list.size() - 1; i > 0; i--) begin
                    rng = xorshift(rng);
                    j = int'(rng % 32'(i + 1));
                    tmp = list[i];
                    list[i] = list[j];
                    list[j] = tmp;
                end
                foreach (list[k]) begin
                    tick();
                    if (m_valid[list[k]]) begin
                        drive_exec(list[k], 1'b0, 32'h0);
                    end
                end
            end
            OP_SDONE: begin
                tick();
                n = 0;
                while (!store_seen) begin
                    tick();
                    n++;
                    if (n > 30) begin
                        abort("timeout waiting for store_en");
                    end
                end
                store_done = 1'b1;
                store_seen = 1'b0;
                store_pop  = 1'b1;
            end
            OP_DRAIN: begin
                n = 0;
                while (order.size() > 0) begin
                    tick();
                    n++;
                    if (n > 60) begin
                        abort("timeout waiting for rf_en or flush to drain the buffer");
                    end
                end
            end
            default: begin
                for (int i = 0; i < r.cnt; i++) begin
                    tick();
                end
            end
        endcase
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        alloc_en   = 1'b0;
        alloc_kind = rob_pkg::KIND_ALU;
        alloc_rd   = '0;
        alloc_pred = 1'b0;
        ex_en      = 1'b0;
        ex_tag     = '0;
        ex_data    = '0;
        ex_taken   = 1'b0;
        ex_target  = '0;
        store_done = 1'b0;
        store_pop  = 1'b0;
        rng        = 32'h644d_3f4a;
        clear_model();

        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < N_ROWS; i++) begin
            run_row(rows[i]);
        end
        tick();

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
source/rob_pkg.sv
source/rob_ptr_counter.sv
source/rob_entry_store.sv
source/rob_commit_fsm.sv
source/rob_top.sv
bench/rob_assertions.sv
bench/rob_tb.sv

/* run.sh */
#!/bin/sh
# build and run the ROB testbench, result taken from sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module rob_tb \
    -o rob_sim > build.log 2>&1 \
    && ./obj_dir/rob_sim > sim.log 2>&1 \
    && grep -qx '>>> PASS' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
